// File: common/pad_dma_pkg.sv
// Shared widths, burst constants and tile geometry for the padding DMA
// Burst lengths follow the AXI convention of beats minus one
// The tile edge also sets the number of tile rows and the read burst length

package pad_dma_pkg;

    // Bus widths
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // Tile geometry
    parameter int TILE = 4;                 // Words per tile edge
    parameter int IDX_W = $clog2(TILE);     // Tile-local row or column index

    // Byte stride between consecutive words
    parameter int WORD_BYTES = 4;

    // Burst length field width, as on AxLEN
    parameter int LEN_W = 4;

    // Every source read is one tile row
    parameter logic [LEN_W-1:0] RD_LEN = LEN_W'(TILE - 1);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

endpackage

// File: hw/tile_row.sv
`timescale 1ns/1ps
// One source row of the tile buffer, TILE words
// Write port from the reader, asynchronous read port for the writer

module tile_row (
    input  logic                          clk,
    input  logic                          wr_i,
    input  logic [pad_dma_pkg::IDX_W-1:0] wr_col_i,
    input  pad_dma_pkg::word_t            wr_data_i,
    input  logic [pad_dma_pkg::IDX_W-1:0] rd_col_i,
    output pad_dma_pkg::word_t            rd_data_o
);
    import pad_dma_pkg::*;

    word_t mem [TILE];

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_col_i] <= wr_data_i;
        end
    end

    // Column already clamped by the writer
    assign rd_data_o = mem[rd_col_i];

endmodule

// File: hw/tile_reader/tile_reader.sv
`timescale 1ns/1ps
// Walks the source blocks in row-major order, one TILE-beat burst per tile row
// Only one read burst is outstanding; the next tile waits for tile_written_i
// Assumes the slave returns exactly TILE beats with rlast_i on the final one

module tile_reader #(
    parameter int MAX_DIM = 32,
    localparam int DIM_W = $clog2(MAX_DIM + 1),
    localparam int BLK_W = (MAX_DIM > pad_dma_pkg::TILE) ?
                           $clog2(MAX_DIM / pad_dma_pkg::TILE) : 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  pad_dma_pkg::addr_t            src_addr_i,
    input  logic [DIM_W-1:0]              width_i,
    output logic                          done_o,

    output pad_dma_pkg::addr_t            araddr_o,
    output logic [pad_dma_pkg::LEN_W-1:0] arlen_o,
    output logic                          arvalid_o,
    input  logic                          arready_i,
    input  pad_dma_pkg::word_t            rdata_i,
    input  logic                          rlast_i,
    input  logic                          rvalid_i,
    output logic                          rready_o,

    output logic [pad_dma_pkg::TILE-1:0]  row_wr_o,
    output logic [pad_dma_pkg::IDX_W-1:0] col_o,
    output pad_dma_pkg::word_t            data_o,

    output logic                          tile_ready_o,
    output logic [BLK_W-1:0]              block_x_o,
    output logic [BLK_W-1:0]              block_y_o,
    output logic                          first_col_o,
    output logic                          last_col_o,
    output logic                          first_row_o,
    output logic                          last_row_o,
    input  logic                          tile_written_i
);
    import pad_dma_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_AR, S_R, S_WAIT} state_t;

    state_t           state;
    logic             done_q;
    logic [BLK_W-1:0] bx_q;
    logic [BLK_W-1:0] by_q;
    logic [BLK_W-1:0] last_blk;
    logic [IDX_W-1:0] rrow_q;           // Tile row being fetched
    logic [IDX_W-1:0] rcol_q;           // Beat within the row burst
    addr_t            src_q;
    logic [DIM_W-1:0] width_q;
    addr_t            row_idx;
    addr_t            word_off;
    logic             start_ok;
    logic             r_hs;

    assign start_ok = (state == S_IDLE) && start_i && (width_i != '0);
    assign r_hs     = rvalid_i && rready_o;
    assign last_blk = BLK_W'((width_q / TILE) - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            done_q <= 1'b1;
            bx_q   <= '0;
            by_q   <= '0;
            rrow_q <= '0;
            rcol_q <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_ok) begin
                        done_q <= 1'b0;
                        bx_q   <= '0;
                        by_q   <= '0;
                        rrow_q <= '0;
                        state  <= S_AR;
                    end
                end
                S_AR: begin
                    if (arready_i) begin
                        rcol_q <= '0;
                        state  <= S_R;
                    end
                end
                S_R: begin
                    if (r_hs) begin
                        rcol_q <= rcol_q + 1'b1;
                        if (rlast_i && tile_ready_o) begin
                            state <= S_WAIT;    // Tile complete, hand to writer
                        end else if (rlast_i) begin
                            rrow_q <= rrow_q + 1'b1;
                            state  <= S_AR;
                        end
                    end
                end
                S_WAIT: begin
                    if (tile_written_i) begin
                        if (bx_q == last_blk && by_q == last_blk) begin
                            done_q <= 1'b1;
                            state  <= S_IDLE;
                        end else begin
                            rrow_q <= '0;
                            state  <= S_AR;
                            if (bx_q == last_blk) begin
                                bx_q <= '0;
                                by_q <= by_q + 1'b1;
                            end else begin
                                bx_q <= bx_q + 1'b1;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Run settings, captured on an accepted start
    always_ff @(posedge clk) begin
        if (start_ok) begin
            src_q   <= src_addr_i;
            width_q <= width_i;
        end
    end

    // Source word offset of the current tile row start
    assign row_idx  = addr_t'(by_q) * TILE + addr_t'(rrow_q);
    assign word_off = row_idx * addr_t'(width_q) + addr_t'(bx_q) * TILE;

    assign araddr_o  = src_q + word_off * WORD_BYTES;
    assign arlen_o   = RD_LEN;
    assign arvalid_o = (state == S_AR);
    assign rready_o  = (state == S_R);
    assign done_o    = done_q;

    // Steer each beat into the tile row being fetched
    assign row_wr_o = r_hs ? (TILE'(1) << rrow_q) : '0;
    assign col_o    = rcol_q;
    assign data_o   = rdata_i;

    assign tile_ready_o = r_hs && rlast_i && (rrow_q == IDX_W'(TILE - 1));
    assign block_x_o    = bx_q;
    assign block_y_o    = by_q;
    assign first_col_o  = (bx_q == '0);
    assign last_col_o   = (bx_q == last_blk);
    assign first_row_o  = (by_q == '0);
    assign last_row_o   = (by_q == last_blk);

endmodule

// File: hw/pad_writer/pad_writer.sv
`timescale 1ns/1ps
// Writes one padded tile as one burst per destination row, TILE to TILE+2 beats
// dst_addr_i and width_i are sampled on tile_ready_i and must be stable per run
// One write burst outstanding; B is expected only after the last W beat

module pad_writer #(
    parameter int MAX_DIM = 32,
    localparam int DIM_W = $clog2(MAX_DIM + 1),
    localparam int BLK_W = (MAX_DIM > pad_dma_pkg::TILE) ?
                           $clog2(MAX_DIM / pad_dma_pkg::TILE) : 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  pad_dma_pkg::addr_t            dst_addr_i,
    input  logic [DIM_W-1:0]              width_i,

    input  logic                          tile_ready_i,
    input  logic [BLK_W-1:0]              block_x_i,
    input  logic [BLK_W-1:0]              block_y_i,
    input  logic                          first_col_i,
    input  logic                          last_col_i,
    input  logic                          first_row_i,
    input  logic                          last_row_i,
    output logic                          tile_written_o,

    output logic [pad_dma_pkg::IDX_W-1:0] rd_row_o,
    output logic [pad_dma_pkg::IDX_W-1:0] rd_col_o,
    input  pad_dma_pkg::word_t            rd_data_i,

    output pad_dma_pkg::addr_t            awaddr_o,
    output logic [pad_dma_pkg::LEN_W-1:0] awlen_o,
    output logic                          awvalid_o,
    input  logic                          awready_i,
    output pad_dma_pkg::word_t            wdata_o,
    output logic                          wlast_o,
    output logic                          wvalid_o,
    input  logic                          wready_i,
    input  logic                          bvalid_i,
    output logic                          bready_o
);
    import pad_dma_pkg::*;

    localparam int CNT_W = $clog2(TILE + 2);

    typedef enum logic [1:0] {S_IDLE, S_AW, S_W, S_B} state_t;

    state_t           state;
    logic [CNT_W-1:0] row_cnt;          // Destination row within the tile
    logic [CNT_W-1:0] col_cnt;          // Beat within the row burst
    logic [CNT_W-1:0] rows_m1;
    logic [CNT_W-1:0] cols_m1;
    addr_t            dst_q;
    logic [DIM_W-1:0] width_q;
    logic [BLK_W-1:0] bx_q;
    logic [BLK_W-1:0] by_q;
    logic             fc_q;
    logic             lc_q;
    logic             fr_q;
    logic             lr_q;
    addr_t            pitch;
    addr_t            dst_row;
    addr_t            dst_col;
    logic             w_hs;
    logic             b_hs;
    logic             row_done;

    // Map a padded index to a tile-local index in 0..TILE-1
    function automatic logic [IDX_W-1:0] clamp_idx(input logic [CNT_W-1:0] cnt,
                                                   input logic first);
        logic [CNT_W-1:0] v;
        v = cnt - CNT_W'(first);
        if (first && cnt == '0) begin
            return '0;                  // Replicated row or column before the edge
        end else if (v > CNT_W'(TILE - 1)) begin
            return IDX_W'(TILE - 1);    // Replicated row or column after the edge
        end
        return v[IDX_W-1:0];
    endfunction

    assign rows_m1  = CNT_W'(TILE - 1) + CNT_W'(fr_q) + CNT_W'(lr_q);
    assign cols_m1  = CNT_W'(TILE - 1) + CNT_W'(fc_q) + CNT_W'(lc_q);
    assign w_hs     = wvalid_o && wready_i;
    assign b_hs     = bvalid_i && bready_o;
    assign row_done = b_hs && ((state == S_B) || (w_hs && wlast_o));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            row_cnt <= '0;
            col_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (tile_ready_i) begin
                        row_cnt <= '0;
                        state   <= S_AW;
                    end
                end
                S_AW: begin
                    if (awready_i) begin
                        col_cnt <= '0;
                        state   <= S_W;
                    end
                end
                S_W: begin
                    if (w_hs) begin
                        col_cnt <= col_cnt + 1'b1;
                        if (wlast_o) begin
                            state <= S_B;
                        end
                    end
                end
                S_B: ;                      // Response handled below
                default: state <= S_IDLE;
            endcase
            if (row_done && row_cnt == rows_m1) begin
                state <= S_IDLE;
            end else if (row_done) begin
                row_cnt <= row_cnt + 1'b1;
                state   <= S_AW;
            end
        end
    end

    // Tile geometry, captured with the handoff
    always_ff @(posedge clk) begin
        if (state == S_IDLE && tile_ready_i) begin
            dst_q   <= dst_addr_i;
            width_q <= width_i;
            bx_q    <= block_x_i;
            by_q    <= block_y_i;
            fc_q    <= first_col_i;
            lc_q    <= last_col_i;
            fr_q    <= first_row_i;
            lr_q    <= last_row_i;
        end
    end

    // Edge tiles start one row or column earlier
    assign pitch   = addr_t'(width_q) + 2;
    assign dst_row = addr_t'(by_q) * TILE + addr_t'(row_cnt) + 1 - addr_t'(fr_q);
    assign dst_col = addr_t'(bx_q) * TILE + 1 - addr_t'(fc_q);

    assign awaddr_o  = dst_q + (dst_row * pitch + dst_col) * WORD_BYTES;
    assign awlen_o   = LEN_W'(cols_m1);
    assign awvalid_o = (state == S_AW);

    assign rd_row_o = clamp_idx(row_cnt, fr_q);
    assign rd_col_o = clamp_idx(col_cnt, fc_q);

    assign wdata_o  = rd_data_i;
    assign wvalid_o = (state == S_W);
    assign wlast_o  = (state == S_W) && (col_cnt == cols_m1);
    assign bready_o = (state == S_W) || (state == S_B);

    assign tile_written_o = row_done && (row_cnt == rows_m1);

endmodule

// File: hw/pad_dma_top.sv
`timescale 1ns/1ps
// Edge-replication padding DMA, N x N source to (N+2) x (N+2) destination
// N must be a multiple of TILE and at most MAX_DIM; width zero is ignored
// dst_addr_i and width_i must stay stable while done_o is low

module pad_dma_top #(
    parameter int MAX_DIM = 32,
    localparam int DIM_W = $clog2(MAX_DIM + 1)
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         start_i,
    input  pad_dma_pkg::addr_t           src_addr_i,
    input  pad_dma_pkg::addr_t           dst_addr_i,
    input  logic [DIM_W-1:0]             width_i,
    output logic                         done_o,

    // Read address and data channels
    output pad_dma_pkg::addr_t           araddr_o,
    output logic [pad_dma_pkg::LEN_W-1:0] arlen_o,
    output logic                         arvalid_o,
    input  logic                         arready_i,
    input  pad_dma_pkg::word_t           rdata_i,
    input  logic                         rlast_i,
    input  logic                         rvalid_i,
    output logic                         rready_o,

    // Write address, data and response channels
    output pad_dma_pkg::addr_t           awaddr_o,
    output logic [pad_dma_pkg::LEN_W-1:0] awlen_o,
    output logic                         awvalid_o,
    input  logic                         awready_i,
    output pad_dma_pkg::word_t           wdata_o,
    output logic                         wlast_o,
    output logic                         wvalid_o,
    input  logic                         wready_i,
    input  logic                         bvalid_i,
    output logic                         bready_o
);
    import pad_dma_pkg::*;

    localparam int BLK_W = (MAX_DIM > TILE) ? $clog2(MAX_DIM / TILE) : 1;

    // Reader to tile buffer
    logic [TILE-1:0]  row_wr;
    logic [IDX_W-1:0] wr_col;
    word_t            wr_data;

    // Writer to tile buffer
    logic [IDX_W-1:0] rd_row;
    logic [IDX_W-1:0] rd_col;
    word_t            row_data [TILE];
    word_t            rd_data;

    // Reader to writer handoff
    logic             tile_ready;
    logic             tile_written;
    logic [BLK_W-1:0] block_x;
    logic [BLK_W-1:0] block_y;
    logic             first_col;
    logic             last_col;
    logic             first_row;
    logic             last_row;

    tile_reader #(
        .MAX_DIM(MAX_DIM)
    ) u_reader (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .src_addr_i    (src_addr_i),
        .width_i       (width_i),
        .done_o        (done_o),
        .araddr_o      (araddr_o),
        .arlen_o       (arlen_o),
        .arvalid_o     (arvalid_o),
        .arready_i     (arready_i),
        .rdata_i       (rdata_i),
        .rlast_i       (rlast_i),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready_o),
        .row_wr_o      (row_wr),
        .col_o         (wr_col),
        .data_o        (wr_data),
        .tile_ready_o  (tile_ready),
        .block_x_o     (block_x),
        .block_y_o     (block_y),
        .first_col_o   (first_col),
        .last_col_o    (last_col),
        .first_row_o   (first_row),
        .last_row_o    (last_row),
        .tile_written_i(tile_written)
    );

    // One storage row per source row of the tile
    for (genvar g = 0; g < TILE; g++) begin : g_row
        tile_row u_row (
            .clk      (clk),
            .wr_i     (row_wr[g]),
            .wr_col_i (wr_col),
            .wr_data_i(wr_data),
            .rd_col_i (rd_col),
            .rd_data_o(row_data[g])
        );
    end

    assign rd_data = row_data[rd_row];  // Row select for the writer

    pad_writer #(
        .MAX_DIM(MAX_DIM)
    ) u_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .dst_addr_i    (dst_addr_i),
        .width_i       (width_i),
        .tile_ready_i  (tile_ready),
        .block_x_i     (block_x),
        .block_y_i     (block_y),
        .first_col_i   (first_col),
        .last_col_i    (last_col),
        .first_row_i   (first_row),
        .last_row_i    (last_row),
        .tile_written_o(tile_written),
        .rd_row_o      (rd_row),
        .rd_col_o      (rd_col),
        .rd_data_i     (rd_data),
        .awaddr_o      (awaddr_o),
        .awlen_o       (awlen_o),
        .awvalid_o     (awvalid_o),
        .awready_i     (awready_i),
        .wdata_o       (wdata_o),
        .wlast_o       (wlast_o),
        .wvalid_o      (wvalid_o),
        .wready_i      (wready_i),
        .bvalid_i      (bvalid_i),
        .bready_o      (bready_o)
    );

endmodule

// File: sim/pad_dma_chk.sv
`timescale 1ns/1ps
// Bus protocol assertions bound into every pad_dma_top
// Open read and write bursts are tracked from the handshakes seen on the ports

module pad_dma_chk (
    input logic                          clk,
    input logic                          rst_n,
    input pad_dma_pkg::addr_t            araddr_o,
    input logic [pad_dma_pkg::LEN_W-1:0] arlen_o,
    input logic                          arvalid_o,
    input logic                          arready_i,
    input logic                          rlast_i,
    input logic                          rvalid_i,
    input logic                          rready_o,
    input pad_dma_pkg::addr_t            awaddr_o,
    input logic [pad_dma_pkg::LEN_W-1:0] awlen_o,
    input logic                          awvalid_o,
    input logic                          awready_i,
    input pad_dma_pkg::word_t            wdata_o,
    input logic                          wlast_o,
    input logic                          wvalid_o,
    input logic                          wready_i,
    input logic                          bvalid_i,
    input logic                          bready_o
);
    logic rd_open;      // Between AR handshake and last R beat
    logic wr_open;      // Between AW handshake and B
    int   failures = 0; // Assertion failures seen so far

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_open <= 1'b0;
            wr_open <= 1'b0;
        end else begin
            if (arvalid_o && arready_i) begin
                rd_open <= 1'b1;
            end else if (rvalid_i && rready_o && rlast_i) begin
                rd_open <= 1'b0;
            end
            if (awvalid_o && awready_i) begin
                wr_open <= 1'b1;
            end else if (bvalid_i && bready_o) begin
                wr_open <= 1'b0;
            end
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arlen_o))
        else begin
            $error("AR request dropped or changed before arready");
            failures++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awlen_o))
        else begin
            $error("AW request dropped or changed before awready");
            failures++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wlast_o))
        else begin
            $error("W beat dropped or changed before wready");
            failures++;
        end

    rready_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
        rready_o |-> rd_open)
        else begin
            $error("rready_o high outside a read burst");
            failures++;
        end

    bready_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        bready_o |-> wr_open)
        else begin
            $error("bready_o high outside a write burst");
            failures++;
        end

    wlast_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        wlast_o |-> wvalid_o)
        else begin
            $error("wlast_o high without wvalid_o");
            failures++;
        end

endmodule

bind pad_dma_top pad_dma_chk u_chk (.*);

// File: sim/pad_dma_tb.sv
`timescale 1ns/1ps
// Testbench for pad_dma_top with a memory slave that stalls at random
// Source and destination regions do not overlap; all widths stay within MAX_DIM

module pad_dma_tb;
    import pad_dma_pkg::*;

    localparam int MAX_DIM     = 16;
    localparam int DIM_W       = $clog2(MAX_DIM + 1);
    localparam int DST_WORDS   = (MAX_DIM + 2) * (MAX_DIM + 2);
    localparam int N_TESTS     = 4;
    localparam int STALL_BOUND = 24;    // Cycles allowed per moved word
    localparam addr_t SRC_BASE = 32'h0000_4000;
    localparam addr_t DST_BASE = 32'h0002_0000;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             start_i;
    addr_t            src_addr_i;
    addr_t            dst_addr_i;
    logic [DIM_W-1:0] width_i;
    logic             done_o;
    addr_t            araddr_o;
    logic [LEN_W-1:0] arlen_o;
    logic             arvalid_o;
    logic             arready_i;
    word_t            rdata_i;
    logic             rlast_i;
    logic             rvalid_i;
    logic             rready_o;
    addr_t            awaddr_o;
    logic [LEN_W-1:0] awlen_o;
    logic             awvalid_o;
    logic             awready_i;
    word_t            wdata_o;
    logic             wlast_o;
    logic             wvalid_o;
    logic             wready_i;
    logic             bvalid_i;
    logic             bready_o;

    int dims [N_TESTS]   = '{4, 12, 16, 8};
    int stalls [N_TESTS] = '{0, 0, 50, 30};    // Percent of cycles held off

    word_t src_mem [MAX_DIM * MAX_DIM];
    int    dst_hits [DST_WORDS];
    int    width;                       // N of the running test
    int    stall_pct;

    // Slave state with one burst outstanding per direction
    bit rd_busy;
    int rd_idx;
    int rd_beat;
    bit wr_busy;
    int wr_idx;
    int wr_beat;
    int wr_len;
    bit b_pend;

    int aw_cnt;
    int b_cnt;
    int active_cycles;
    int errors;
    int tests_run;
    int tests_failed;
    int cycles;
    int cycle_limit;

    pad_dma_top #(
        .MAX_DIM(MAX_DIM)
    ) DUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic int clamp(input int v, input int n);
        if (v < 0) begin
            return 0;
        end
        if (v > n - 1) begin
            return n - 1;
        end
        return v;
    endfunction

    // Destination word from the edge replication rule
    function automatic word_t expected_word(input int r, input int c);
        return src_mem[clamp(r - 1, width) * width + clamp(c - 1, width)];
    endfunction

    // Beats of a row burst that starts at destination column c0
    function automatic int expected_beats(input int c0);
        int bx;
        if (c0 == 0) begin
            return (width == TILE) ? TILE + 2 : TILE + 1;
        end
        bx = (c0 - 1) / TILE;
        return (bx == width / TILE - 1) ? TILE + 1 : TILE;
    endfunction

    function automatic bit no_stall();
        return ($urandom % 100) >= stall_pct;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("ERROR t=%0t %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        tests_run++;
        if (errors != start_err) begin
            tests_failed++;
        end
        $display("test %-26s %s (%0d errors)", name,
                 (errors == start_err) ? "ok" : "failed", errors - start_err);
    endtask

    task automatic accept_read(input addr_t addr, input logic [LEN_W-1:0] len);
        int idx;
        bit ok;
        idx = int'((addr - SRC_BASE) / WORD_BYTES);
        ok  = addr >= SRC_BASE && addr[1:0] == 2'b00 && idx >= 0
              && idx + TILE <= width * width && idx % width + TILE <= width;
        check_value("arlen_o", len, TILE - 1);
        check_true(ok, "read burst outside the source matrix");
        rd_busy = 1'b1;
        rd_beat = 0;
        rd_idx  = ok ? idx : 0;
    endtask

    task automatic accept_write(input addr_t addr, input logic [LEN_W-1:0] len);
        int idx;
        int col;
        bit ok;
        idx = int'((addr - DST_BASE) / WORD_BYTES);
        col = idx % (width + 2);
        ok  = addr >= DST_BASE && addr[1:0] == 2'b00 && idx >= 0
              && idx < (width + 2) * (width + 2) && col + int'(len) + 1 <= width + 2;
        aw_cnt++;
        check_true(ok, "write burst outside the destination matrix");
        if (ok) begin
            check_value("awlen_o", len, expected_beats(col) - 1);
        end
        wr_busy = 1'b1;
        wr_beat = 0;
        wr_len  = int'(len);
        wr_idx  = ok ? idx : -1;
    endtask

    task automatic take_beat(input word_t data, input logic last);
        int idx;
        int r;
        int c;
        idx = wr_idx + wr_beat;
        r   = idx / (width + 2);
        c   = idx % (width + 2);
        check_value("wlast_o", last, wr_beat == wr_len);
        if (wr_busy && wr_idx >= 0 && wr_beat <= wr_len) begin
            dst_hits[idx]++;
            check_value($sformatf("wdata_o[%0d][%0d]", r, c), data, expected_word(r, c));
        end
        wr_beat++;
        if (last || wr_beat > wr_len) begin
            wr_busy = 1'b0;
            b_pend  = 1'b1;             // Response only after the last beat
        end
    endtask

    // Memory slave samples handshakes mid-cycle and answers after the edge
    always begin : mem_slave
        bit r_hs;
        bit b_hs;
        @(negedge clk);
        r_hs = rvalid_i && rready_o;
        b_hs = bvalid_i && bready_o;
        if (arvalid_o || awvalid_o || wvalid_o) begin
            active_cycles++;
        end
        if (arvalid_o) begin
            check_true(!rd_busy, "read address issued while a read burst was open");
        end
        if (awvalid_o) begin
            check_true(!wr_busy && !b_pend, "write address issued while a write burst was open");
        end
        if (wvalid_o) begin
            check_true(wr_busy, "write data offered without an open write burst");
        end
        if (arvalid_o && arready_i) begin
            accept_read(araddr_o, arlen_o);
        end
        if (r_hs) begin
            rd_beat++;
            if (rd_beat == TILE) begin
                rd_busy = 1'b0;
            end
        end
        if (awvalid_o && awready_i) begin
            accept_write(awaddr_o, awlen_o);
        end
        if (wvalid_o && wready_i) begin
            take_beat(wdata_o, wlast_o);
        end
        if (b_hs) begin
            b_pend = 1'b0;
            b_cnt++;
        end
        @(posedge clk);
        #1;
        arready_i = rst_n && !rd_busy && no_stall();
        if (!(rvalid_i && !r_hs)) begin
            rvalid_i = rd_busy && no_stall();
        end
        rdata_i   = rd_busy ? src_mem[rd_idx + rd_beat] : '0;
        rlast_i   = rd_busy && rd_beat == TILE - 1;
        awready_i = rst_n && !wr_busy && !b_pend && no_stall();
        wready_i  = wr_busy && no_stall();
        if (!(bvalid_i && !b_hs)) begin
            bvalid_i = b_pend && no_stall();
        end
    end

    task automatic run_zero_width();
        int start_err;
        int act;
        start_err  = errors;
        act        = active_cycles;
        start_i    = 1'b1;
        src_addr_i = SRC_BASE;
        dst_addr_i = DST_BASE;
        width_i    = '0;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        repeat (8) begin
            check_value("done_o", done_o, 1'b1);
            @(posedge clk);
            #1;
        end
        check_true(active_cycles == act, "start with width 0 caused bus activity");
        report_test("zero width start", start_err);
    endtask

    task automatic run_pad(input int n, input int pct);
        int start_err;
        int dn;
        int bursts;
        start_err = errors;
        width     = n;
        stall_pct = pct;
        dn        = n + 2;
        bursts    = (n / TILE) * dn;    // One burst per destination row of each tile
        foreach (src_mem[i]) begin
            src_mem[i] = $urandom;
        end
        foreach (dst_hits[i]) begin
            dst_hits[i] = 0;
        end
        aw_cnt     = 0;
        b_cnt      = 0;
        start_i    = 1'b1;
        src_addr_i = SRC_BASE;
        dst_addr_i = DST_BASE;
        width_i    = DIM_W'(n);
        @(posedge clk);
        #1;
        start_i = 1'b0;
        check_value("done_o", done_o, 1'b0);
        while (!done_o) begin
            @(posedge clk);
            #1;
        end
        check_true(b_cnt == bursts && !b_pend, "done_o rose before the last write response");
        check_value("write bursts", aw_cnt, bursts);
        for (int r = 0; r < dn; r++) begin
            for (int c = 0; c < dn; c++) begin
                check_value($sformatf("writes to [%0d][%0d]", r, c), dst_hits[r * dn + c], 1);
            end
        end
        report_test($sformatf("width %0d, %0d%% stalls", n, pct), start_err);
    endtask

    initial begin
        int words;
        int start_err;
        void'($urandom(32'h9b3f));
        words = 0;
        foreach (dims[i]) begin
            words += dims[i] * dims[i] + (dims[i] + 2) * (dims[i] + 2);
        end
        cycle_limit = words * STALL_BOUND + 200;
        stall_pct   = 0;
        width       = TILE;
        rst_n       = 1'b0;
        start_i     = 1'b0;
        src_addr_i  = '0;
        dst_addr_i  = '0;
        width_i     = '0;
        arready_i   = 1'b0;
        rdata_i     = '0;
        rlast_i     = 1'b0;
        rvalid_i    = 1'b0;
        awready_i   = 1'b0;
        wready_i    = 1'b0;
        bvalid_i    = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_err = errors;
        check_value("done_o", done_o, 1'b1);
        check_value("arvalid_o", arvalid_o, 1'b0);
        check_value("awvalid_o", awvalid_o, 1'b0);
        check_value("wvalid_o", wvalid_o, 1'b0);
        report_test("reset state", start_err);

        run_zero_width();
        foreach (dims[i]) begin
            run_pad(dims[i], stalls[i]);
        end

        start_err = errors;
        check_true(DUT.u_chk.failures == 0, "bus protocol assertions failed in the checker");
        report_test("bus protocol", start_err);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
common/pad_dma_pkg.sv
hw/tile_row.sv
hw/tile_reader/tile_reader.sv
hw/pad_writer/pad_writer.sv
hw/pad_dma_top.sv
sim/pad_dma_chk.sv
sim/pad_dma_tb.sv
